/* aesKeySchedule.f */
+incdir+dv
src/aesDataPkg.sv
src/keySchedPkg.sv
src/subWord.sv
src/keyExpander.sv
src/roundKeyStore.sv
src/aesKeySchedule.sv
dv/aesKeySchedule_tb.sv

/* dv/keyScheduleModel.svh */
// ----------------------------------------------------------------------
// reference model of the AES-128 key schedule for the testbench
// included inside the testbench module, needs the aesDataPkg types
// ----------------------------------------------------------------------
`ifndef KEY_SCHEDULE_MODEL_SVH
`define KEY_SCHEDULE_MODEL_SVH

typedef logic [NumRounds:0][127:0] keyTable;  // index is the round number

// GF(2^8) product, reduction by x^8 + x^4 + x^3 + x + 1
function automatic aesByte gfMul(aesByte a, aesByte b);
  aesByte prod;
  aesByte acc;
  prod = '0;
  acc  = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      prod = prod ^ acc;
    end
    acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1b : 8'h00);  // times x
  end
  return prod;
endfunction

// a^254 by square and multiply, zero stays zero
function automatic aesByte gfInv(aesByte a);
  aesByte sq;
  aesByte acc;
  sq  = a;
  acc = 8'h01;
  for (int i = 1; i < 8; i++) begin
    sq  = gfMul(sq, sq);   // a^(2^i)
    acc = gfMul(acc, sq);
  end
  return acc;
endfunction

// inverse, then the affine map with constant 0x63
function automatic aesByte sboxModel(aesByte a);
  aesByte b;
  b = gfInv(a);
  return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^
         {b[3:0], b[7:4]} ^ 8'h63;
endfunction

function automatic aesWord subWordModel(aesWord w);
  return {sboxModel(w[31:24]), sboxModel(w[23:16]), sboxModel(w[15:8]), sboxModel(w[7:0])};
endfunction

function automatic aesWord rotWordModel(aesWord w);
  return {w[23:0], w[31:24]};  // first byte moves to the end
endfunction

// rounds 0..10 from the cipher key
function automatic keyTable expandForward(aesBlock key);
  keyTable rk;
  aesByte  rc;
  aesWord  t;
  aesWord  w0, w1, w2, w3;
  rk[0] = key;
  rc    = RconFirst;
  for (int r = 1; r <= NumRounds; r++) begin
    {w0, w1, w2, w3} = rk[r-1];
    t  = subWordModel(rotWordModel(w3)) ^ {rc, 24'h00_0000};
    w0 = w0 ^ t;
    w1 = w1 ^ w0;
    w2 = w2 ^ w1;
    w3 = w3 ^ w2;
    rk[r] = {w0, w1, w2, w3};
    rc    = gfMul(rc, 8'h02);
  end
  return rk;
endfunction

// rounds 10 down to 0 from the last round key
function automatic keyTable expandReverse(aesBlock key10);
  keyTable rk;
  aesByte  rcTab [1:NumRounds];
  aesByte  rc;
  aesWord  c0, c1, c2, c3;
  aesWord  p0, p1, p2, p3;
  rc = RconFirst;
  for (int r = 1; r <= NumRounds; r++) begin
    rcTab[r] = rc;  // constant used to build round r
    rc       = gfMul(rc, 8'h02);
  end
  rk[NumRounds] = key10;
  for (int r = NumRounds; r > 0; r--) begin
    {c0, c1, c2, c3} = rk[r];
    p3 = c3 ^ c2;
    p2 = c2 ^ c1;
    p1 = c1 ^ c0;
    p0 = c0 ^ subWordModel(rotWordModel(p3)) ^ {rcTab[r], 24'h00_0000};
    rk[r-1] = {p0, p1, p2, p3};
  end
  return rk;
endfunction

`endif

/* dv/aesKeySchedule_tb.sv */
// ----------------------------------------------------------------------
// testbench for the AES-128 key schedule top
// table keys, LCG keys, stray starts and a mid-sequence reset
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module aesKeySchedule_tb
  import aesDataPkg::*;
  import keySchedPkg::*;
();

  localparam int BeatCount  = 2*NumRounds + 1;  // 11 forward, 10 backward
  localparam int WaitLimit  = 50;               // cycles per wait
  localparam int RandomKeys = 4;
  localparam int TableSize  = 3;

  typedef struct packed {
    aesBlock key;
    logic    busyStart;  // pulse start again mid-sequence
    aesBlock round10;    // published last round key
  } stimEntry;

  logic        clk;
  logic        reset;
  logic        start;
  aesBlock     cipherKey;
  roundIndex   readRound;
  roundKeyBeat beat;
  logic        beatValid;
  logic        busy;
  aesBlock     readKey;

  int          errorCount;
  int          checkCount;
  int          timeoutCount;
  logic [31:0] lcgState;
  stimEntry    stimTable [0:TableSize-1];

  `include "keyScheduleModel.svh"

  aesKeySchedule dut_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cipherKey (cipherKey),
    .readRound (readRound),
    .beat      (beat),
    .beatValid (beatValid),
    .busy      (busy),
    .readKey   (readKey)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
  endfunction

  task automatic drawKey(output aesBlock key);
    key = '0;
    for (int i = 0; i < 4; i++) begin
      lcgState = lcgNext(lcgState);
      key      = {key[95:0], lcgState};
    end
  endtask

  task automatic reportMismatch(string msg);
    errorCount++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  // beatValid still low on return means a timeout
  task automatic waitForValid(output int lag);
    lag = 0;
    while (!beatValid && lag < WaitLimit) begin
      @(negedge clk);
      lag++;
    end
    if (!beatValid) begin
      errorCount++;
      timeoutCount++;
      $display("timed out after %0d cycles waiting for beatValid to rise", WaitLimit);
    end
  endtask

  task automatic waitForIdle();
    int cycles;
    cycles = 0;
    while (busy && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      errorCount++;
      timeoutCount++;
      $display("timed out after %0d cycles waiting for busy to fall", WaitLimit);
    end
  endtask

  // sweep of all 16 read codes between falling edges
  task automatic checkStore(keyTable rk, logic cleared);
    aesBlock expKey;
    for (int r = 0; r < 16; r++) begin
      readRound = roundIndex'(r);
      @(negedge clk);
      if (r <= NumRounds && !cleared) begin
        expKey = rk[r];
      end else begin
        expKey = '0;  // unused codes and cleared store
      end
      checkCount++;
      if (readKey !== expKey) begin
        reportMismatch($sformatf("store round %0d got %h expected %h", r, readKey, expKey));
      end
    end
  endtask

  task automatic runSequence(aesBlock key, logic busyStart, logic hasRef, aesBlock ref10);
    keyTable     rk;
    keyTable     back;
    roundKeyBeat expBeat;
    int          lag;
    rk   = expandForward(key);
    back = expandReverse(rk[NumRounds]);
    checkCount++;
    if (back !== rk) begin
      reportMismatch($sformatf("model reverse expansion disagrees for key %h", key));
    end
    if (hasRef) begin
      checkCount++;
      if (rk[NumRounds] !== ref10) begin
        reportMismatch($sformatf("model round 10 %h, published %h", rk[NumRounds], ref10));
      end
    end
    @(negedge clk);
    cipherKey = key;
    start     = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    cipherKey = ~key;  // only the start edge may sample the key
    waitForValid(lag);
    if (beatValid) begin
      checkCount++;
      if (lag != 0) begin
        reportMismatch($sformatf("beatValid rose %0d cycles late", lag));
      end
      for (int idx = 0; idx < BeatCount; idx++) begin
        if (idx > 0) begin
          @(negedge clk);
        end
        if (idx <= NumRounds) begin
          expBeat.key   = rk[idx];
          expBeat.round = roundIndex'(idx);
          expBeat.dir   = forward;
        end else begin
          expBeat.key   = rk[BeatCount-1-idx];  // 9 down to 0
          expBeat.round = roundIndex'(BeatCount-1-idx);
          expBeat.dir   = backward;
        end
        expBeat.last = (idx == BeatCount-1);
        checkCount++;
        if (!beatValid || !busy) begin
          reportMismatch($sformatf("beat %0d valid %b busy %b, both expected high",
                                   idx, beatValid, busy));
        end
        checkCount++;
        if (beat !== expBeat) begin
          reportMismatch($sformatf("beat %0d got r%0d d%0d l%b %h, expected r%0d d%0d l%b %h",
                                   idx, beat.round, beat.dir, beat.last, beat.key,
                                   expBeat.round, expBeat.dir, expBeat.last, expBeat.key));
        end
        start = busyStart && (idx == 4);  // stray start while busy
      end
      @(negedge clk);
      start = 1'b0;
      checkCount++;
      if (beatValid || busy) begin
        reportMismatch($sformatf("after last beat valid %b busy %b, both expected low",
                                 beatValid, busy));
      end
      waitForIdle();
      checkStore(rk, 1'b0);
    end
  endtask

  task automatic resetMidSequence(aesBlock key);
    keyTable rk;
    int      lag;
    rk = '0;
    @(negedge clk);
    cipherKey = key;
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    waitForValid(lag);
    if (beatValid) begin
      repeat (6) @(negedge clk);  // store now holds a few forward rounds
      reset = 1'b1;
      @(negedge clk);
      reset = 1'b0;
      checkCount++;
      if (beatValid || busy || beat.last) begin
        reportMismatch($sformatf("after reset valid %b busy %b last %b, all expected low",
                                 beatValid, busy, beat.last));
      end
      checkStore(rk, 1'b1);
    end
  endtask

  initial begin
    stimEntry entry;
    aesBlock  key;
    keyTable  emptyTable;
    start        = 1'b0;
    reset        = 1'b1;
    cipherKey    = '0;
    readRound    = '0;
    errorCount   = 0;
    checkCount   = 0;
    timeoutCount = 0;
    lcgState     = 32'h7180_6cd9;
    emptyTable   = '0;
    // key, busyStart and round10 per entry
    stimTable[0] = {128'h2b7e1516_28aed2a6_abf71588_09cf4f3c, 1'b0,
                    128'hd014f9a8_c9ee2589_e13f0cc8_b6630ca6};  // FIPS-197 A.1
    stimTable[1] = {128'h0, 1'b1,
                    128'hb4ef5bcb_3e92e211_23e951cf_6f8f188e};
    stimTable[2] = {{128{1'b1}}, 1'b1,
                    128'hd60a3588_e472f07b_82d2d785_8cd7c326};

    repeat (3) @(negedge clk);
    reset = 1'b0;
    checkCount++;
    if (beatValid || busy || beat.last) begin
      reportMismatch("beatValid, busy or last high after reset");
    end
    checkStore(emptyTable, 1'b1);

    for (int i = 0; i < TableSize; i++) begin
      entry = stimTable[i];
      runSequence(entry.key, entry.busyStart, 1'b1, entry.round10);
    end

    for (int n = 0; n < RandomKeys; n++) begin
      drawKey(key);
      runSequence(key, (n == 1), 1'b0, '0);  // one stray start among them
    end

    entry = stimTable[0];
    resetMidSequence(entry.key);
    runSequence(entry.key, 1'b0, 1'b1, entry.round10);  // clean run after reset

    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : aesKeySchedule_tb

/* src/aesKeySchedule.sv */
// ----------------------------------------------------------------------
// AES-128 key schedule top, expander plus round-key store
// stream port feeds decryption, lookup port feeds encryption
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module aesKeySchedule
  import aesDataPkg::*;
  import keySchedPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,      // one-cycle strobe
  input  aesBlock     cipherKey,
  input  roundIndex   readRound,  // lookup index for the cipher rounds
  output roundKeyBeat beat,       // no back-pressure, take it or lose it
  output logic        beatValid,
  output logic        busy,
  output aesBlock     readKey
);

  // expander drives the stream, the store listens to the same beat
  keyExpander expander_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cipherKey (cipherKey),
    .beat      (beat),
    .beatValid (beatValid),
    .busy      (busy)
  );

  roundKeyStore store_i (
    .clk       (clk),
    .reset     (reset),
    .beat      (beat),
    .beatValid (beatValid),
    .readRound (readRound),
    .readKey   (readKey)
  );

endmodule : aesKeySchedule

/* src/roundKeyStore.sv */
// ----------------------------------------------------------------------
// round-key store for the encryption datapath
// captures forward beats, read combinationally by round number
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module roundKeyStore
  import aesDataPkg::*;
  import keySchedPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  roundKeyBeat beat,
  input  logic        beatValid,
  input  roundIndex   readRound,
  output aesBlock     readKey
);

  aesBlock keyMem [0:NumRounds];  // one block per round
  logic    writeEn;

  // backward beats repeat keys already held, so only forward ones write
  assign writeEn = beatValid && (beat.dir == forward) && (beat.round <= NumRounds);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i <= NumRounds; i++) begin
        keyMem[i] <= '0;
      end
    end else if (writeEn) begin
      keyMem[beat.round] <= beat.key;  // visible from next cycle
    end
  end

  // codes 11..15 read as zero
  assign readKey = (readRound <= NumRounds) ? keyMem[readRound] : '0;

  // expander never emits a forward round past 10
  writeInRange: assert property (@(posedge clk) disable iff (reset)
    (beatValid && beat.dir == forward) |-> (beat.round <= NumRounds));

endmodule : roundKeyStore

/* src/keyExpander.sv */
// ----------------------------------------------------------------------
// AES-128 key expansion FSM, one round key per cycle
// start loads the key, then 11 forward beats and 10 reverse beats follow
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module keyExpander
  import aesDataPkg::*;
  import keySchedPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,      // ignored while busy
  input  aesBlock     cipherKey,  // sampled with an accepted start
  output roundKeyBeat beat,
  output logic        beatValid,
  output logic        busy
);

  expandState state;
  aesBlock    prevBlock;  // round key currently on the output
  aesByte     rcon;       // constant for the next forward step
  roundIndex  roundCnt;
  expandDir   dir;

  aesWord  w0, w1, w2, w3;  // words of prevBlock, w0 first
  aesWord  schedWord;       // word fed to rotate and substitute
  aesWord  rotWord;
  aesWord  subOut;
  aesWord  mixWord;         // substituted word with the constant folded in
  aesWord  f0, f1, f2, f3;  // forward chain
  aesByte  rconNext;
  aesByte  rconBack;
  aesByte  rconUse;
  aesBlock fwdBlock;
  aesBlock revBlock;
  aesBlock nextBlock;
  logic    stepBack;        // next step runs the inverse recurrence
  logic    startOk;

  assign startOk = start && (state == idle);

  // turnaround happens while the round-10 beat is out
  assign stepBack = (state == reverseRun) ||
                    ((state == forwardRun) && (roundCnt == NumRounds));

  assign {w0, w1, w2, w3} = prevBlock;

  // in reverse the earlier last word is w3 ^ w2 of this block
  assign schedWord = stepBack ? (w3 ^ w2) : w3;
  assign rotWord   = {schedWord[23:0], schedWord[31:24]};  // RotWord, one byte left

  subWord subRot_i (
    .wordIn  (rotWord),
    .wordOut (subOut)
  );

  // multiply by x, reduce by the AES polynomial
  assign rconNext = {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
  // multiply by x^-1, i.e. add 0x11b when odd and shift down
  assign rconBack = rcon[0] ? ({1'b0, rcon[7:1]} ^ 8'h8d) : {1'b0, rcon[7:1]};
  assign rconUse  = stepBack ? rconBack : rcon;  // reverse uses the undone round's constant

  assign mixWord = subOut ^ {rconUse, 24'h00_0000};

  // forward chain through the four words
  assign f0       = w0 ^ mixWord;
  assign f1       = w1 ^ f0;
  assign f2       = w2 ^ f1;
  assign f3       = w3 ^ f2;
  assign fwdBlock = {f0, f1, f2, f3};

  // inverse, neighbours give words 1..3, word 0 needs the S-box path
  assign revBlock  = {w0 ^ mixWord, w1 ^ w0, w2 ^ w1, w3 ^ w2};
  assign nextBlock = stepBack ? revBlock : fwdBlock;

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      roundCnt  <= '0;
      dir       <= forward;
      rcon      <= RconFirst;
      beatValid <= 1'b0;
    end else begin
      unique case (state)
        idle: begin
          if (startOk) begin
            state     <= loadKey;
            roundCnt  <= '0;
            dir       <= forward;
            rcon      <= RconFirst;
            beatValid <= 1'b1;  // round 0 goes out next cycle
          end
        end
        loadKey: begin
          state    <= forwardRun;
          roundCnt <= roundCnt + 4'd1;
          rcon     <= rconNext;
        end
        forwardRun: begin
          if (roundCnt == NumRounds) begin  // turn around
            state    <= reverseRun;
            dir      <= backward;
            roundCnt <= roundCnt - 4'd1;
            rcon     <= rconBack;
          end else begin
            roundCnt <= roundCnt + 4'd1;
            rcon     <= rconNext;
          end
        end
        reverseRun: begin
          if (roundCnt == '0) begin  // round 0 was the last beat
            state     <= idle;
            beatValid <= 1'b0;
          end else begin
            roundCnt <= roundCnt - 4'd1;
            rcon     <= rconBack;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // round-key register, payload only
  always_ff @(posedge clk) begin
    if (startOk) begin
      prevBlock <= cipherKey;
    end else if (state != idle) begin
      prevBlock <= nextBlock;
    end
  end

  assign beat.key   = prevBlock;
  assign beat.round = roundCnt;
  assign beat.dir   = dir;
  assign beat.last  = (state == reverseRun) && (roundCnt == '0);
  assign busy       = (state != idle);

  // stream must never show valid outside a running sequence
  validNeedsBusy: assert property (@(posedge clk) disable iff (reset)
    beatValid |-> busy);

  // final beat is the recovered cipher key
  lastIsRoundZero: assert property (@(posedge clk) disable iff (reset)
    (beatValid && beat.last) |-> (beat.round == '0) && (beat.dir == backward));

  // forward rounds advance one per cycle with no gaps
  forwardStepsByOne: assert property (@(posedge clk) disable iff (reset)
    (beatValid && beat.dir == forward) ##1 (beatValid && beat.dir == forward)
      |-> beat.round == $past(beat.round) + 4'd1);

endmodule : keyExpander

/* src/subWord.sv */
// ----------------------------------------------------------------------
// AES S-box applied to all four bytes of a word, purely combinational
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module subWord
  import aesDataPkg::*;
(
  input  aesWord wordIn,
  output aesWord wordOut
);

  // forward S-box, row n holds entries 16n..16n+15
  localparam aesByte SBox [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // four independent lookups, one per byte lane
  for (genvar lane = 0; lane < 4; lane++) begin : genLane
    aesByte byteIn;
    assign byteIn = wordIn[8*lane +: 8];
    assign wordOut[8*lane +: 8] = SBox[byteIn];  // lane position is kept
  end

endmodule : subWord

/* src/keySchedPkg.sv */
// ----------------------------------------------------------------------
// key-schedule control types and the round-key output beat
// import together with the AES data types in every schedule block
// ----------------------------------------------------------------------
package keySchedPkg;

  import aesDataPkg::*;

  // which recurrence produced a beat
  typedef enum logic {
    forward  = 1'b0,  // encryption order, round 0 up to 10
    backward = 1'b1   // decryption order, round 9 down to 0
  } expandDir;

  // expander FSM
  typedef enum logic [1:0] {
    idle       = 2'd0,  // waiting for start
    loadKey    = 2'd1,  // cipher key on the output as round 0
    forwardRun = 2'd2,  // rounds 1..10
    reverseRun = 2'd3   // rounds 9..0
  } expandState;

  // one round key on the stream, 134 bits
  typedef struct packed {
    aesBlock   key;    // round key
    roundIndex round;  // round it belongs to
    expandDir  dir;
    logic      last;   // final beat of the whole sequence
  } roundKeyBeat;

endpackage : keySchedPkg

/* src/aesDataPkg.sv */
// ----------------------------------------------------------------------
// AES data types and algorithm constants for the key schedule
// import wherever bytes, words, blocks or round numbers are handled
// ----------------------------------------------------------------------
package aesDataPkg;

  // one GF(2^8) element
  typedef logic [7:0] aesByte;

  // one schedule word, four bytes, byte 0 in the top bits
  typedef logic [31:0] aesWord;

  // cipher key or round key, word 0 in bits 127:96
  typedef logic [127:0] aesBlock;

  // round number 0..10, codes 11..15 unused
  typedef logic [3:0] roundIndex;

  // AES-128 has ten rounds after the initial key add
  localparam int NumRounds = 10;

  // round constant for the first expansion step
  localparam aesByte RconFirst = 8'h01;

endpackage : aesDataPkg
